// ==== pmp_pkg.sv ====
// Shared widths, CSR addresses and encodings for the PMP unit
// Every PMP source file takes these by a wildcard import in its module header
package pmp_pkg;

	// --------------------------------------------------
	// Widths and region count

	// Query address width in bits
	localparam int W_ADDR = 32;
	// CSR data width in bits
	localparam int W_DATA = 32;
	// Four regions per config word, at most 32 because of the M-enable word
	localparam int PMP_REGIONS = 4;

	// --------------------------------------------------
	// CSR addresses

	// First config word, later words follow at consecutive addresses
	localparam logic [11:0] PMPCFG0 = 12'h3A0;
	// First address register, one address per region
	localparam logic [11:0] PMPADDR0 = 12'h3B0;
	// Custom word that applies regions to M-mode without locking them
	localparam logic [11:0] PMPCFGM0 = 12'hBD0;

	// --------------------------------------------------
	// Address-mode field of a config byte

	localparam logic [1:0] PMP_A_OFF = 2'b00;
	// TOR is not implemented and gets stored as OFF
	localparam logic [1:0] PMP_A_TOR = 2'b01;
	localparam logic [1:0] PMP_A_NA4 = 2'b10;
	localparam logic [1:0] PMP_A_NAPOT = 2'b11;

	// One CSR word seen two ways
	// The byte view is used for config words, with byte n holding region n of the word
	// The raw view is used for address registers and the M-enable word
	typedef union packed {
		logic [3:0][7:0] cfg_byte;
		logic [W_DATA-1:0] raw;
	} pmp_cfg_word_u;

endpackage

// ==== pmp_region_if.sv ====
// Per-region config bits and decoded match values of the PMP unit
// The register block and the decoder drive it, the two access checkers read it
`timescale 1ns/1ps

interface pmp_region_if import pmp_pkg::*; ();

	// Address mode of each region, OFF, NA4 or NAPOT
	logic [PMP_REGIONS-1:0][1:0] region_a;

	// Lock, read, write, execute and M-enable bits, one per region
	logic [PMP_REGIONS-1:0] region_l;
	logic [PMP_REGIONS-1:0] region_r;
	logic [PMP_REGIONS-1:0] region_w;
	logic [PMP_REGIONS-1:0] region_x;
	logic [PMP_REGIONS-1:0] region_m;

	// Address registers hold bits 31:2 of a byte address
	logic [PMP_REGIONS-1:0][W_ADDR-3:0] region_addr;

	// Decoded byte-address mask and compare value of each region
	logic [PMP_REGIONS-1:0][W_ADDR-1:0] match_mask;
	logic [PMP_REGIONS-1:0][W_ADDR-1:0] match_addr;

	modport regs (
		output region_a, region_l, region_r, region_w, region_x, region_m, region_addr
	);

	modport decode (
		input region_a, region_addr,
		output match_mask, match_addr
	);

	modport check (
		input region_a, region_l, region_r, region_w, region_x, region_m,
		input match_mask, match_addr
	);

endinterface

// ==== pmp_cfg_regs.sv ====
// Config, address and M-enable registers of the PMP unit
// Writes come from a CSR strobe port and take effect on the write edge
// Readback is combinational from the CSR address
`timescale 1ns/1ps

module pmp_cfg_regs import pmp_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,

	// CSR-style access port
	input  logic [11:0]       i_cfg_addr,
	input  logic              i_cfg_wen,
	input  logic [W_DATA-1:0] i_cfg_wdata,
	output logic [W_DATA-1:0] o_cfg_rdata,

	// Region state towards decoder and checkers
	pmp_region_if.regs        rif
);

	// Write word, viewed as config bytes or as a raw word
	pmp_cfg_word_u wr_word;

	// Readback word, assembled byte by byte for config words
	pmp_cfg_word_u rd_word;

	assign wr_word.raw = i_cfg_wdata;

	// --------------------------------------------------
	// Register update

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// All regions come out of reset OFF with every bit clear
			rif.region_a <= '0;
			rif.region_l <= '0;
			rif.region_r <= '0;
			rif.region_w <= '0;
			rif.region_x <= '0;
			rif.region_m <= '0;
			rif.region_addr <= '0;
		end else if (i_cfg_wen) begin
			for (int i = 0; i < PMP_REGIONS; i++) begin
				// Region i lives in byte i%4 of config word i/4
				// A locked region ignores config writes until the next reset
				if (i_cfg_addr == 12'(PMPCFG0 + i / 4) && !rif.region_l[i]) begin
					rif.region_l[i] <= wr_word.cfg_byte[i % 4][7];
					rif.region_r[i] <= wr_word.cfg_byte[i % 4][2];
					rif.region_w[i] <= wr_word.cfg_byte[i % 4][1];
					rif.region_x[i] <= wr_word.cfg_byte[i % 4][0];
					// TOR is a legal write but is held as OFF
					rif.region_a[i] <= (wr_word.cfg_byte[i % 4][4:3] == PMP_A_TOR) ?
						PMP_A_OFF : wr_word.cfg_byte[i % 4][4:3];
				end
				// The lock also freezes the address register of the same region
				if (i_cfg_addr == 12'(PMPADDR0 + i) && !rif.region_l[i]) begin
					rif.region_addr[i] <= wr_word.raw[W_ADDR-3:0];
				end
			end
			// The M-enable word is never locked, upper bits are dropped
			if (i_cfg_addr == PMPCFGM0) begin
				rif.region_m <= wr_word.raw[PMP_REGIONS-1:0];
			end
		end
	end

	// --------------------------------------------------
	// Combinational readback

	always_comb begin
		// Unknown addresses fall through and read as zero
		rd_word.raw = '0;
		for (int i = 0; i < PMP_REGIONS; i++) begin
			if (i_cfg_addr == 12'(PMPCFG0 + i / 4)) begin
				// Reserved bits 6:5 always read as zero
				rd_word.cfg_byte[i % 4] = {
					rif.region_l[i],
					2'b00,
					rif.region_a[i],
					rif.region_r[i],
					rif.region_w[i],
					rif.region_x[i]
				};
			end else if (i_cfg_addr == 12'(PMPADDR0 + i)) begin
				// Bits 31:30 of the word have no storage and stay zero
				rd_word.raw[W_ADDR-3:0] = rif.region_addr[i];
			end
		end
		if (i_cfg_addr == PMPCFGM0) begin
			rd_word.raw = W_DATA'(rif.region_m);
		end
	end

	assign o_cfg_rdata = rd_word.raw;

endmodule

// ==== pmp_region_decode.sv ====
// Decoder from region mode and address register to a byte-address match pair
// A query address matches a region when (addr & mask) == match address
`timescale 1ns/1ps

module pmp_region_decode import pmp_pkg::*; (
	pmp_region_if.decode rif
);

	// Address register layout for the modes in use
	//   NA4    y..yyyyy  covers 4 bytes
	//   NAPOT  y..yyyy0  covers 8 bytes
	//   NAPOT  y..yyy01  covers 16 bytes
	//   NAPOT  y..yy011  covers 32 bytes
	// For NAPOT only the bits above the lowest zero are compared

	always_comb begin : decode_regions
		logic [W_ADDR-1:0] mask;
		for (int i = 0; i < PMP_REGIONS; i++) begin
			if (rif.region_a[i] == PMP_A_NA4) begin
				// Naturally aligned 4 bytes, so every bit above the byte offset counts
				mask = {{(W_ADDR-2){1'b1}}, 2'b00};
			end else begin
				// Bits 2:0 never take part since NAPOT covers at least 8 bytes
				mask = '0;
				for (int j = 3; j < W_ADDR; j++) begin
					// Once a zero is seen in the address register, all higher bits count
					mask[j] = mask[j-1] | ~rif.region_addr[i][j-3];
				end
			end
			// OFF regions still get a mask, the checkers gate them on the mode
			rif.match_mask[i] = mask;
			// Byte address of the region base, with the size bits cleared
			rif.match_addr[i] = {rif.region_addr[i], 2'b00} & mask;
		end
	end

endmodule

// ==== pmp_data_check.sv ====
// Load/store permission check of the PMP unit
// Combinational from the query inputs to the kill output
`timescale 1ns/1ps

module pmp_data_check import pmp_pkg::*; (
	// Load/store query
	input  logic [W_ADDR-1:0] i_d_addr,
	input  logic              i_d_m_mode,
	input  logic              i_d_write,
	output logic              o_d_kill,

	// Region state
	pmp_region_if.check       rif
);

	// Attributes of the lowest matching region, all zero when nothing matches
	logic d_l;
	logic d_m;
	logic d_r;
	logic d_w;

	// Whether the permission bits apply to this access
	logic rule_applies;

	// --------------------------------------------------
	// Priority lookup

	always_comb begin : lookup
		logic hit;
		d_l = 1'b0;
		d_m = 1'b0;
		d_r = 1'b0;
		d_w = 1'b0;
		// Walk from the top so the lowest-numbered matching region is left standing
		for (int i = PMP_REGIONS - 1; i >= 0; i--) begin
			hit = (|rif.region_a[i]) &&
				((i_d_addr & rif.match_mask[i]) == rif.match_addr[i]);
			if (hit) begin
				d_l = rif.region_l[i];
				d_m = rif.region_m[i];
				d_r = rif.region_r[i];
				d_w = rif.region_w[i];
			end
		end
	end

	// --------------------------------------------------
	// Load/store rule

	// M-mode is only checked against locked or M-enabled regions
	assign rule_applies = !i_d_m_mode || d_l || d_m;

	// Stores need write permission, loads need read permission
	assign o_d_kill = rule_applies && !(i_d_write ? d_w : d_r);

endmodule

// ==== pmp_fetch_check.sv ====
// Instruction-fetch permission check of the PMP unit
// Both halfwords of a fetch are looked up so a 32-bit instruction that
// straddles a region boundary is caught
`timescale 1ns/1ps

module pmp_fetch_check import pmp_pkg::*; (
	// Fetch query
	input  logic [W_ADDR-1:0] i_i_addr,
	input  logic              i_i_instr_is_32bit,
	input  logic              i_i_m_mode,
	output logic              o_i_kill,

	// Region state
	pmp_region_if.check       rif
);

	// Address of the second halfword of the fetch
	logic [W_ADDR-1:0] addr_hw1;

	// Attributes of the deciding region, all zero when nothing matches
	logic i_partial;
	logic i_l;
	logic i_m;
	logic i_x;

	// Whether the permission bits apply to this fetch
	logic rule_applies;

	assign addr_hw1 = i_i_addr + W_ADDR'(2);

	// --------------------------------------------------
	// Priority lookup over both halfwords

	always_comb begin : lookup
		logic hit_hw0;
		logic hit_hw1;
		i_partial = 1'b0;
		i_l = 1'b0;
		i_m = 1'b0;
		i_x = 1'b0;
		// The lowest region touching either halfword decides the whole fetch
		// A partial hit there is only allowed if a lower region fully matches
		for (int i = PMP_REGIONS - 1; i >= 0; i--) begin
			hit_hw0 = (|rif.region_a[i]) &&
				((i_i_addr & rif.match_mask[i]) == rif.match_addr[i]);
			hit_hw1 = (|rif.region_a[i]) &&
				((addr_hw1 & rif.match_mask[i]) == rif.match_addr[i]);
			if (hit_hw0 || hit_hw1) begin
				// A 16-bit instruction only needs the first halfword to match
				i_partial = (hit_hw0 ^ hit_hw1) && i_i_instr_is_32bit;
				i_l = rif.region_l[i];
				i_m = rif.region_m[i];
				i_x = rif.region_x[i];
			end
		end
	end

	// --------------------------------------------------
	// Execute rule

	assign rule_applies = !i_i_m_mode || i_l || i_m;

	// A straddling instruction is killed in every mode
	assign o_i_kill = i_partial || (rule_applies && !i_x);

endmodule

// ==== pmp_unit.sv ====
// Physical memory protection unit with four regions
// CSR-style config port plus a load/store query and a fetch query,
// both answered combinationally every cycle
`timescale 1ns/1ps

module pmp_unit import pmp_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,

	// Config port from the CSR block
	input  logic [11:0]       i_cfg_addr,
	input  logic              i_cfg_wen,
	input  logic [W_DATA-1:0] i_cfg_wdata,
	output logic [W_DATA-1:0] o_cfg_rdata,

	// Fetch query
	input  logic [W_ADDR-1:0] i_i_addr,
	input  logic              i_i_instr_is_32bit,
	input  logic              i_i_m_mode,
	output logic              o_i_kill,

	// Load/store query
	input  logic [W_ADDR-1:0] i_d_addr,
	input  logic              i_d_m_mode,
	input  logic              i_d_write,
	output logic              o_d_kill
);

	// Shared region state between the four blocks
	pmp_region_if u_rif ();

	// Registers and readback
	pmp_cfg_regs u_cfg_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wen   (i_cfg_wen),
		.i_cfg_wdata (i_cfg_wdata),
		.o_cfg_rdata (o_cfg_rdata),
		.rif         (u_rif.regs)
	);

	// Mode and address register to mask and match address
	pmp_region_decode u_region_decode (
		.rif (u_rif.decode)
	);

	pmp_data_check u_data_check (
		.i_d_addr   (i_d_addr),
		.i_d_m_mode (i_d_m_mode),
		.i_d_write  (i_d_write),
		.o_d_kill   (o_d_kill),
		.rif        (u_rif.check)
	);

	pmp_fetch_check u_fetch_check (
		.i_i_addr           (i_i_addr),
		.i_i_instr_is_32bit (i_i_instr_is_32bit),
		.i_i_m_mode         (i_i_m_mode),
		.o_i_kill           (o_i_kill),
		.rif                (u_rif.check)
	);

endmodule

// ==== pmp_unit_properties.sv ====
// Concurrent checks on the PMP unit ports, bound into every pmp_unit instance
// Failed assertions are counted so the testbench can see them
`timescale 1ns/1ps

module pmp_unit_properties import pmp_pkg::*; (
	input logic              clk,
	input logic              rst_n,
	input logic [11:0]       i_cfg_addr,
	input logic              i_cfg_wen,
	input logic [W_DATA-1:0] i_cfg_wdata,
	input logic [W_DATA-1:0] o_cfg_rdata,
	input logic              o_i_kill,
	input logic              o_d_kill
);

	int n_failures = 0;

	// Both kill outputs resolve to 0 or 1 once out of reset
	a_kill_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({o_i_kill, o_d_kill}))
	else begin
		n_failures++;
		$error("Kill output is unknown");
	end

	// The M-enable word reads back the low region bits of the last write
	a_m_enable_readback: assert property (@(posedge clk) disable iff (!rst_n)
		(i_cfg_wen && i_cfg_addr == PMPCFGM0) ##1 (i_cfg_addr == PMPCFGM0)
		|-> (o_cfg_rdata == W_DATA'($past(i_cfg_wdata[PMP_REGIONS-1:0]))))
	else begin
		n_failures++;
		$error("M-enable word does not read back the written region bits");
	end

endmodule

bind pmp_unit pmp_unit_properties u_properties (.*);

// ==== tb_pmp_unit.sv ====
// Self-checking testbench for the PMP unit
// A shadow of the region registers predicts the readback and both kill outputs every cycle
// Run with the file list, top module tb_pmp_unit
`timescale 1ns/1ps

module tb_pmp_unit import pmp_pkg::*; ();

	localparam int N_RAND = 200;
	// Length of all tests together plus a margin, in clock cycles
	localparam int TOTAL_CYCLES = 11 * N_RAND + 200;

	logic              clk;
	logic              rst_n;
	logic [11:0]       i_cfg_addr;
	logic              i_cfg_wen;
	logic [W_DATA-1:0] i_cfg_wdata;
	logic [W_DATA-1:0] o_cfg_rdata;
	logic [W_ADDR-1:0] i_i_addr;
	logic              i_i_instr_is_32bit;
	logic              i_i_m_mode;
	logic              o_i_kill;
	logic [W_ADDR-1:0] i_d_addr;
	logic              i_d_m_mode;
	logic              i_d_write;
	logic              o_d_kill;

	// Shadow config bytes as they read back, address registers and M-enable bits
	logic [PMP_REGIONS-1:0][7:0]        sh_cfg;
	logic [PMP_REGIONS-1:0][W_ADDR-3:0] sh_addr;
	logic [PMP_REGIONS-1:0]             sh_m;
	// Window that random query addresses are drawn from
	logic [W_ADDR-1:0] q_base;
	logic [W_ADDR-1:0] q_span;
	string test_name;

	pmp_unit DUT (.*);

	initial begin : clock_gen
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------------------------------------
	// Reference model

	// NA4 covers 4 bytes, NAPOT with k trailing ones covers 2^(k+3) bytes
	function automatic logic ref_hit(int i, logic [W_ADDR-1:0] addr);
		int k;
		k = 0;
		if (sh_cfg[i][4:3] == PMP_A_NA4) begin
			return addr[W_ADDR-1:2] == sh_addr[i];
		end
		if (sh_cfg[i][4:3] != PMP_A_NAPOT) begin
			return 1'b0;
		end
		while (k < W_ADDR - 2 && sh_addr[i][k]) begin
			k++;
		end
		return (addr >> (k + 3)) == ({sh_addr[i], 2'b00} >> (k + 3));
	endfunction

	// The lowest region hit by the query decides, a fetch also looks at its second halfword
	function automatic logic ref_kill(logic fetch, logic [W_ADDR-1:0] addr, logic is32,
		logic m_mode, logic write);
		logic h0;
		logic h1;
		for (int i = 0; i < PMP_REGIONS; i++) begin
			h0 = ref_hit(i, addr);
			h1 = fetch && ref_hit(i, W_ADDR'(addr + 2));
			if (h0 || h1) begin
				// A 32-bit instruction half inside the region is killed in any mode
				if (fetch && is32 && (h0 != h1)) begin
					return 1'b1;
				end
				if (m_mode && !sh_cfg[i][7] && !sh_m[i]) begin
					return 1'b0;
				end
				return fetch ? !sh_cfg[i][0] : (write ? !sh_cfg[i][1] : !sh_cfg[i][2]);
			end
		end
		// No region matched, so only M-mode gets through
		return !m_mode;
	endfunction

	function automatic logic [W_DATA-1:0] ref_readback(logic [11:0] addr);
		logic [W_DATA-1:0] word;
		word = '0;
		for (int i = 0; i < PMP_REGIONS; i++) begin
			if (addr == PMPCFG0 + i / 4) begin
				word[8*(i%4) +: 8] = sh_cfg[i];
			end
			if (addr == PMPADDR0 + i) begin
				word = W_DATA'(sh_addr[i]);
			end
		end
		if (addr == PMPCFGM0) begin
			word = W_DATA'(sh_m);
		end
		return word;
	endfunction

	task automatic shadow_write(logic [11:0] addr, logic [W_DATA-1:0] data);
		logic [7:0] b;
		for (int i = 0; i < PMP_REGIONS; i++) begin
			b = data[8*(i%4) +: 8];
			// Locked regions keep both their config byte and their address
			if (addr == PMPCFG0 + i / 4 && !sh_cfg[i][7]) begin
				sh_cfg[i] = {b[7], 2'b00, ((b[4:3] == PMP_A_TOR) ? PMP_A_OFF : b[4:3]), b[2:0]};
			end
			if (addr == PMPADDR0 + i && !sh_cfg[i][7]) begin
				sh_addr[i] = data[W_ADDR-3:0];
			end
		end
		if (addr == PMPCFGM0) begin
			sh_m = data[PMP_REGIONS-1:0];
		end
	endtask

	// --------------------------------------------------
	// Checking

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "Run stopped on the first error");
	endtask

	task automatic expect_equal(string name, logic [W_DATA-1:0] expected,
		logic [W_DATA-1:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			fail_run("Output differs from the reference model");
		end
	endtask

	// The write of the previous cycle lands on this edge, outputs are checked 1 ns later
	always @(posedge clk) begin : compare
		if (rst_n && i_cfg_wen) begin
			shadow_write(i_cfg_addr, i_cfg_wdata);
		end
		#1;
		if (!rst_n) begin
			sh_cfg = '0;
			sh_addr = '0;
			sh_m = '0;
		end
		expect_equal({test_name, " cfg_rdata"}, ref_readback(i_cfg_addr), o_cfg_rdata);
		expect_equal({test_name, " d_kill"},
			W_DATA'(ref_kill(1'b0, i_d_addr, 1'b0, i_d_m_mode, i_d_write)), W_DATA'(o_d_kill));
		expect_equal({test_name, " i_kill"},
			W_DATA'(ref_kill(1'b1, i_i_addr, i_i_instr_is_32bit, i_i_m_mode, 1'b0)),
			W_DATA'(o_i_kill));
		if (DUT.u_properties.n_failures != 0) begin
			fail_run("A concurrent assertion on the DUT failed");
		end
	end

	initial begin : watchdog
		#(TOTAL_CYCLES * 4);
		fail_run($sformatf("Timeout, tests did not finish within %0d cycles", TOTAL_CYCLES));
	end

	// --------------------------------------------------
	// Stimulus

	// One cycle with a config access and random queries on both ports
	task automatic drive(logic [11:0] addr, logic wen, logic [W_DATA-1:0] data);
		@(posedge clk);
		i_cfg_addr <= addr;
		i_cfg_wen <= wen;
		i_cfg_wdata <= data;
		i_i_addr <= (q_base + $urandom_range(0, q_span)) & ~32'h1;
		i_i_instr_is_32bit <= $urandom_range(0, 1);
		i_i_m_mode <= $urandom_range(0, 1);
		i_d_addr <= q_base + $urandom_range(0, q_span);
		i_d_m_mode <= $urandom_range(0, 1);
		i_d_write <= $urandom_range(0, 1);
	endtask

	// Write, then hold the address for a readback cycle
	task automatic cfg_write(logic [11:0] addr, logic [W_DATA-1:0] data);
		drive(addr, 1'b1, data);
		drive(addr, 1'b0, '0);
	endtask

	task automatic idle_cycles(int n);
		repeat (n) drive(PMPCFG0, 1'b0, '0);
	endtask

	task automatic fetch_at(logic [W_ADDR-1:0] addr, logic is32, logic m_mode);
		drive(PMPCFG0, 1'b0, '0);
		i_i_addr <= addr;
		i_i_instr_is_32bit <= is32;
		i_i_m_mode <= m_mode;
	endtask

	// Last halfword of the 16-byte region at 0x5000, both widths and modes
	task automatic straddle_cycles();
		for (int k = 0; k < 4; k++) begin
			fetch_at(32'h0000_500E, k[0], k[1]);
		end
		idle_cycles(N_RAND / 2);
	endtask

	// Covers the config and address range plus the M-enable word
	task automatic read_all_csrs();
		for (int a = 0; a < 32; a++) begin
			drive(12'(PMPCFG0 + a), 1'b0, '0);
		end
		drive(PMPCFGM0, 1'b0, '0);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		i_cfg_wen <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	initial begin : main
		logic [11:0] addr;
		logic [W_DATA-1:0] data;
		void'($urandom(32'h11fe_c126));
		rst_n = 1'b0;
		i_cfg_addr = '0;
		i_cfg_wen = 1'b0;
		i_cfg_wdata = '0;
		i_i_addr = '0;
		i_i_instr_is_32bit = 1'b0;
		i_i_m_mode = 1'b0;
		i_d_addr = '0;
		i_d_m_mode = 1'b0;
		i_d_write = 1'b0;
		q_base = '0;
		q_span = '1;
		test_name = "reset_state";
		apply_reset();
		read_all_csrs();
		idle_cycles(N_RAND / 2);

		test_name = "cfg_readback";
		for (int n = 0; n < N_RAND; n++) begin
			case ($urandom_range(0, 3))
				0: addr = PMPCFG0;
				1: addr = 12'(PMPADDR0 + $urandom_range(0, PMP_REGIONS - 1));
				2: addr = PMPCFGM0;
				default: addr = 12'($urandom);
			endcase
			data = $urandom;
			// Locking is rare so that most regions keep taking writes
			if ($urandom_range(0, 7) != 0) begin
				data &= 32'h7f7f_7f7f;
			end
			cfg_write(addr, data);
			drive(12'($urandom), 1'b0, '0);
		end

		// NA4 at 0x1000, NAPOT of 8, 64 and 4096 bytes at 0x2000, 0x3000 and 0x8000
		test_name = "data_regions";
		apply_reset();
		cfg_write(12'(PMPADDR0), 32'h0000_0400);
		cfg_write(12'(PMPADDR0 + 1), 32'h0000_0800);
		cfg_write(12'(PMPADDR0 + 2), 32'h0000_0C07);
		cfg_write(12'(PMPADDR0 + 3), 32'h0000_21FF);
		cfg_write(PMPCFG0, 32'h1B1D_1E14);
		for (int r = 0; r < 4; r++) begin
			q_base = 32'h1000 * (r == 3 ? 8 : r + 1) - 16;
			q_span = (r == 3) ? 32'd4128 : (32'd4 << r) + 32;
			idle_cycles(N_RAND / 2);
		end

		// Region 0 with 16 bytes read-only lies inside region 1 with 64 bytes read-write
		test_name = "priority";
		apply_reset();
		cfg_write(12'(PMPADDR0), 32'h0000_1001);
		cfg_write(12'(PMPADDR0 + 1), 32'h0000_1007);
		cfg_write(PMPCFG0, 32'h0000_1E1C);
		q_base = 32'h3FF0;
		q_span = 32'h60;
		idle_cycles(N_RAND / 2);
		cfg_write(PMPCFGM0, 32'hFFFF_FFF1);
		idle_cycles(N_RAND / 2);

		// Region 1 alone, then region 0 covering the straddle with and without x
		test_name = "fetch_straddle";
		apply_reset();
		q_base = 32'h4FF0;
		q_span = 32'h40;
		cfg_write(12'(PMPADDR0 + 1), 32'h0000_1401);
		cfg_write(PMPCFG0, 32'h0000_1900);
		straddle_cycles();
		cfg_write(12'(PMPADDR0), 32'h0000_1403);
		cfg_write(PMPCFG0, 32'h0000_1919);
		straddle_cycles();
		cfg_write(PMPCFG0, 32'h0000_191C);
		straddle_cycles();

		// Region 2 locked as read-only NA4 at 0x6000
		test_name = "lock";
		apply_reset();
		q_base = 32'h5FF8;
		q_span = 32'h10;
		cfg_write(12'(PMPADDR0 + 2), 32'h0000_1800);
		cfg_write(PMPCFG0, 32'h0094_0000);
		for (int n = 0; n < 10; n++) begin
			cfg_write(PMPCFG0, $urandom);
			cfg_write(12'(PMPADDR0 + 2), $urandom);
		end
		idle_cycles(N_RAND / 2);
		test_name = "lock_cleared";
		apply_reset();
		read_all_csrs();
		// The last driven cycle is compared before the run ends
		@(posedge clk);

		if (DUT.u_properties.n_failures != 0) begin
			fail_run("A concurrent assertion on the DUT failed");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// ==== flist.f ====
pmp_pkg.sv
pmp_region_if.sv
pmp_cfg_regs.sv
pmp_region_decode.sv
pmp_data_check.sv
pmp_fetch_check.sv
pmp_unit.sv
pmp_unit_properties.sv
tb_pmp_unit.sv
